/* design/rv_pkg.sv */
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] opc_lui       = 7'b0110111;
	localparam logic [6:0] opc_auipc     = 7'b0010111;
	localparam logic [6:0] opc_jal       = 7'b1101111;
	localparam logic [6:0] opc_jalr      = 7'b1100111;
	localparam logic [6:0] opc_branch    = 7'b1100011;
	localparam logic [6:0] opc_load      = 7'b0000011;
	localparam logic [6:0] opc_store     = 7'b0100011;
	localparam logic [6:0] opc_arith_imm = 7'b0010011;
	localparam logic [6:0] opc_arith_reg = 7'b0110011;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem_read,
		st_mem_write
	} state_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_xor,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		cmp_eq,
		cmp_lt,  // Signed
		cmp_ltu
	} cmp_op_e;

	typedef enum logic [3:0] {
		ic_lui,
		ic_auipc,
		ic_jal,
		ic_jalr,
		ic_branch,
		ic_load,
		ic_store,
		ic_arith_imm,
		ic_arith_reg,
		ic_other  // FENCE and anything unknown runs as a no-op
	} iclass_e;

endpackage

/* design/rv_decode_if.sv */
`timescale 1ns/1ps

interface rv_decode_if import rv_pkg::*; ();

	iclass_e iclass;
	alu_op_e alu_op;
	cmp_op_e cmp_op;
	logic cmp_invert;  // BNE, BGE, BGEU
	logic set_less;  // SLT family writes the compare flag
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0] imm;  // Sign-extended, format chosen by class
	logic [2:0] funct3;  // Access size and sign for loads and stores

	modport decoder (
		output iclass, alu_op, cmp_op, cmp_invert, set_less,
		output rs1, rs2, rd, imm, funct3
	);

	modport user (
		input iclass, alu_op, cmp_op, cmp_invert, set_less,
		input rs1, rs2, rd, imm, funct3
	);

endinterface

/* design/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input logic [xlen-1:0] instr,
	rv_decode_if.decoder dec
);

	iclass_e iclass;
	alu_op_e alu_op;
	cmp_op_e cmp_op;
	logic [2:0] funct3;
	logic alt;  // instr[30], picks SUB and SRA
	logic is_arith;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	assign funct3 = instr[14:12];
	assign alt = instr[30];

	always_comb begin
		case (instr[6:0])
			opc_lui:       iclass = ic_lui;
			opc_auipc:     iclass = ic_auipc;
			opc_jal:       iclass = ic_jal;
			opc_jalr:      iclass = ic_jalr;
			opc_branch:    iclass = ic_branch;
			opc_load:      iclass = ic_load;
			opc_store:     iclass = ic_store;
			opc_arith_imm: iclass = ic_arith_imm;
			opc_arith_reg: iclass = ic_arith_reg;
			default:       iclass = ic_other;
		endcase
	end

	assign is_arith = (iclass == ic_arith_imm) || (iclass == ic_arith_reg);

	// Addresses and targets all use add
	always_comb begin
		alu_op = alu_add;
		if (is_arith) begin
			case (funct3)
				3'b000: alu_op = (iclass == ic_arith_reg && alt) ? alu_sub : alu_add;
				3'b001: alu_op = alu_sll;
				3'b100: alu_op = alu_xor;
				3'b101: alu_op = alt ? alu_sra : alu_srl;
				3'b110: alu_op = alu_or;
				3'b111: alu_op = alu_and;
				default: alu_op = alu_add;  // SLT and SLTU use the comparator
			endcase
		end
	end

	always_comb begin
		if (is_arith) begin
			cmp_op = funct3[0] ? cmp_ltu : cmp_lt;
		end else begin
			case (funct3[2:1])
				2'b00: cmp_op = cmp_eq;
				2'b10: cmp_op = cmp_lt;
				default: cmp_op = cmp_ltu;
			endcase
		end
	end

	// Immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (iclass)
			ic_store:         dec.imm = imm_s;
			ic_branch:        dec.imm = imm_b;
			ic_lui, ic_auipc: dec.imm = imm_u;
			ic_jal:           dec.imm = imm_j;
			default:          dec.imm = imm_i;  // Shift amounts sit in imm_i[4:0]
		endcase
	end

	assign dec.iclass = iclass;
	assign dec.alu_op = alu_op;
	assign dec.cmp_op = cmp_op;
	assign dec.cmp_invert = (iclass == ic_branch) && funct3[0];
	assign dec.set_less = is_arith && (funct3[2:1] == 2'b01);
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];
	assign dec.rd = instr[11:7];
	assign dec.funct3 = funct3;

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [reg_addr_w-1:0] ra_addr,
	input logic [reg_addr_w-1:0] rb_addr,
	output logic [xlen-1:0] ra_data,
	output logic [xlen-1:0] rb_data,
	input logic [reg_addr_w-1:0] wr_addr,
	input logic [xlen-1:0] wr_data,
	input logic wr_en
);

	logic [xlen-1:0] regs [0:(1 << reg_addr_w)-1];

	always_ff @(posedge clock) begin
		if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Registered reads, x0 forced to zero
	always_ff @(posedge clock) begin
		if (reset) begin
			ra_data <= '0;
			rb_data <= '0;
		end else begin
			ra_data <= (ra_addr == '0) ? '0 : regs[ra_addr];
			rb_data <= (rb_addr == '0) ? '0 : regs[rb_addr];
		end
	end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	rv_decode_if.user dec,
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] ra_data,
	input logic [xlen-1:0] rb_data,
	output logic [xlen-1:0] result,
	output logic branch_taken,
	output logic less
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] cmp_b;
	logic [4:0] shamt;
	logic cmp_out;

	always_comb begin
		case (dec.iclass)
			ic_lui:                      op_a = '0;
			ic_auipc, ic_jal, ic_branch: op_a = pc;  // PC-relative targets
			default:                     op_a = ra_data;
		endcase
	end

	assign op_b = (dec.iclass == ic_arith_reg) ? rb_data : dec.imm;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_sll: result = op_a << shamt;
			alu_srl: result = op_a >> shamt;
			alu_sra: result = $unsigned($signed(op_a) >>> shamt);
			alu_xor: result = op_a ^ op_b;
			alu_or:  result = op_a | op_b;
			default: result = op_a & op_b;
		endcase
	end

	// Comparator, rs1 against rs2 or the SLTI immediate
	assign cmp_b = (dec.iclass == ic_arith_imm) ? dec.imm : rb_data;

	always_comb begin
		case (dec.cmp_op)
			cmp_eq:  cmp_out = (ra_data == cmp_b);
			cmp_lt:  cmp_out = ($signed(ra_data) < $signed(cmp_b));
			default: cmp_out = (ra_data < cmp_b);
		endcase
	end

	assign less = cmp_out;
	assign branch_taken = (dec.iclass == ic_branch) && (cmp_out != dec.cmp_invert);

endmodule

/* design/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
	rv_decode_if.user dec,
	input logic [xlen-1:0] addr,
	input logic [xlen-1:0] rb_data,
	input logic [xlen-1:0] drdata,
	output logic [xlen-1:0] daddr,
	output logic [xlen-1:0] dwdata,
	output logic [3:0] dstrb,
	output logic [xlen-1:0] load_data
);

	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic ld_signed;

	assign daddr = {addr[xlen-1:2], 2'b00};  // Word aligned, lanes picked by strobes

	// Store data is replicated across the lanes
	always_comb begin
		case (dec.funct3[1:0])
			2'b00: begin
				dstrb = 4'b0001 << addr[1:0];
				dwdata = {4{rb_data[7:0]}};
			end
			2'b01: begin
				dstrb = 4'b0011 << {addr[1], 1'b0};
				dwdata = {2{rb_data[15:0]}};
			end
			default: begin
				dstrb = 4'b1111;
				dwdata = rb_data;
			end
		endcase
	end

	always_comb begin
		case (addr[1:0])
			2'b00: ld_byte = drdata[7:0];
			2'b01: ld_byte = drdata[15:8];
			2'b10: ld_byte = drdata[23:16];
			default: ld_byte = drdata[31:24];
		endcase
	end

	assign ld_half = addr[1] ? drdata[31:16] : drdata[15:0];
	assign ld_signed = !dec.funct3[2];  // LBU and LHU have bit 2 set

	always_comb begin
		case (dec.funct3[1:0])
			2'b00: load_data = {{24{ld_signed & ld_byte[7]}}, ld_byte};
			2'b01: load_data = {{16{ld_signed & ld_half[15]}}, ld_half};
			default: load_data = drdata;
		endcase
	end

endmodule

/* design/rv_control.sv */
`timescale 1ns/1ps

module rv_control import rv_pkg::*; (
	input logic clock,
	input logic reset,
	rv_decode_if.user dec,
	output logic [xlen-1:0] instr,
	input logic [xlen-1:0] idata,
	input logic iready,
	output logic ivalid,
	output logic [xlen-1:0] iaddr,
	input logic dready,
	output logic dvalid,
	output logic dwrite,
	input logic [xlen-1:0] alu_result,
	input logic branch_taken,
	input logic less,
	input logic [xlen-1:0] load_data,
	output logic [xlen-1:0] pc,
	output logic [reg_addr_w-1:0] ra_addr,
	output logic [reg_addr_w-1:0] rb_addr,
	output logic [reg_addr_w-1:0] wr_addr,
	output logic [xlen-1:0] wr_data,
	output logic wr_en
);

	state_e state;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_next;
	logic is_jump;
	logic mem_done;
	logic writes_rd;

	assign ivalid = (state == st_fetch);
	assign iaddr = pc;
	assign dvalid = (state == st_mem_read) || (state == st_mem_write);
	assign dwrite = (state == st_mem_write);
	assign mem_done = dvalid && dready;

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_fetch;
			pc <= reset_vector;
		end else begin
			case (state)
				st_fetch: begin
					if (ivalid && iready) begin
						state <= st_decode;
					end
				end
				st_decode: state <= st_execute;  // Register reads in flight
				st_execute: begin
					if (dec.iclass == ic_load) begin
						state <= st_mem_read;
					end else if (dec.iclass == ic_store) begin
						state <= st_mem_write;
					end else begin
						pc <= pc_next;
						state <= st_fetch;
					end
				end
				st_mem_read, st_mem_write: begin
					if (mem_done) begin
						pc <= pc_next;
						state <= st_fetch;
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

	// Next PC
	assign pc_plus4 = pc + 32'd4;
	assign is_jump = (dec.iclass == ic_jal) || (dec.iclass == ic_jalr);

	always_comb begin
		if (dec.iclass == ic_jalr) begin
			pc_next = {alu_result[xlen-1:1], 1'b0};
		end else if (dec.iclass == ic_jal || branch_taken) begin
			pc_next = alu_result;
		end else begin
			pc_next = pc_plus4;
		end
	end

	assign ra_addr = dec.rs1;
	assign rb_addr = dec.rs2;
	assign wr_addr = dec.rd;

	always_comb begin
		if (is_jump) begin
			wr_data = pc_plus4;  // Link address
		end else if (dec.iclass == ic_load) begin
			wr_data = load_data;
		end else if (dec.set_less) begin
			wr_data = {{(xlen-1){1'b0}}, less};
		end else begin
			wr_data = alu_result;
		end
	end

	always_comb begin
		case (dec.iclass)
			ic_lui, ic_auipc, ic_jal, ic_jalr, ic_arith_imm, ic_arith_reg:
				writes_rd = (state == st_execute);
			ic_load: writes_rd = (state == st_mem_read) && mem_done;
			default: writes_rd = 1'b0;
		endcase
	end

	assign wr_en = writes_rd && (dec.rd != '0);

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input logic clock,
	input logic reset,
	output logic [xlen-1:0] iaddr,
	input logic [xlen-1:0] idata,
	output logic ivalid,
	input logic iready,
	output logic [xlen-1:0] daddr,
	output logic [xlen-1:0] dwdata,
	input logic [xlen-1:0] drdata,
	output logic [3:0] dstrb,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);

	logic [xlen-1:0] instr;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] ra_data;
	logic [xlen-1:0] rb_data;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] wr_data;
	logic [reg_addr_w-1:0] ra_addr;
	logic [reg_addr_w-1:0] rb_addr;
	logic [reg_addr_w-1:0] wr_addr;
	logic wr_en;
	logic branch_taken;
	logic less;

	rv_decode_if dec_if ();

	rv_control u_control (
		.clock        (clock),
		.reset        (reset),
		.dec          (dec_if.user),
		.instr        (instr),
		.idata        (idata),
		.iready       (iready),
		.ivalid       (ivalid),
		.iaddr        (iaddr),
		.dready       (dready),
		.dvalid       (dvalid),
		.dwrite       (dwrite),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.less         (less),
		.load_data    (load_data),
		.pc           (pc),
		.ra_addr      (ra_addr),
		.rb_addr      (rb_addr),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_en        (wr_en)
	);

	rv_decode u_decode (
		.instr (instr),
		.dec   (dec_if.decoder)
	);

	rv_regfile u_regfile (
		.clock   (clock),
		.reset   (reset),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

	rv_alu u_alu (
		.dec          (dec_if.user),
		.pc           (pc),
		.ra_data      (ra_data),
		.rb_data      (rb_data),
		.result       (alu_result),
		.branch_taken (branch_taken),
		.less         (less)
	);

	rv_lsu u_lsu (
		.dec       (dec_if.user),
		.addr      (alu_result),  // Effective address from the ALU
		.rb_data   (rb_data),
		.drdata    (drdata),
		.daddr     (daddr),
		.dwdata    (dwdata),
		.dstrb     (dstrb),
		.load_data (load_data)
	);

endmodule

/* test/tb_core.sv */
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

	localparam logic [31:0] data_base = 32'h0000_1000;

	logic clock, reset;
	logic [31:0] iaddr, idata, daddr, dwdata, drdata;
	logic ivalid, iready, dwrite, dvalid, dready;
	logic [3:0] dstrb;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:63];
	logic [31:0] exp_pc [0:255];  // Fetch order from the model
	logic [31:0] exp_addr [0:63];
	logic [31:0] exp_data [0:63];
	logic [3:0] exp_strb [0:63];
	logic [31:0] m_reg [0:31];
	logic [31:0] pc_gen, rng;
	logic [6:0] cur_op;  // Opcode of the instruction in flight
	int n_trace, n_store, fetch_idx, st_idx, check_errors, other_errors, cycles, limit;

	rv_core dut_i (
		.clock(clock), .reset(reset),
		.iaddr(iaddr), .idata(idata), .ivalid(ivalid), .iready(iready),
		.daddr(daddr), .dwdata(dwdata), .drdata(drdata), .dstrb(dstrb),
		.dwrite(dwrite), .dvalid(dvalid), .dready(dready)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F96;
	endfunction

	// Byte lanes with a strobe bit take the new data
	function automatic logic [31:0] apply_strobes(input logic [31:0] cur,
			input logic [31:0] wdata, input logic [3:0] strb);
		logic [31:0] w;
		w = cur;
		for (int k = 0; k < 4; k++) begin
			if (strb[k]) w[8*k +: 8] = wdata[8*k +: 8];
		end
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	// Reference results from the ISA rules
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] w,
			input logic [1:0] off);
		logic [31:0] s;
		s = w >> {off, 3'b000};
		case (f3)
			3'd0: return {{24{s[7]}}, s[7:0]};
			3'd4: return {24'b0, s[7:0]};
			3'd1: return {{16{s[15]}}, s[15:0]};
			default: return {16'b0, s[15:0]};
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[pc_gen[9:2]] = w;
		exp_pc[n_trace] = pc_gen;
		n_trace++;
		pc_gen = pc_gen + 32'd4;
	endtask

	task automatic emit_skipped(input logic [31:0] w);
		imem[pc_gen[9:2]] = w;  // Jumped over, never fetched
		pc_gen = pc_gen + 32'd4;
	endtask

	task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		emit({hi[19:0], rd, opc_lui});
		emit(enc_i(v[11:0], rd, 3'd0, rd, opc_arith_imm));
		m_reg[rd] = v;
	endtask

	task automatic store_sized(input logic [4:0] rs, input logic [2:0] f3, input logic [1:0] off);
		logic [11:0] imm;
		imm = 12'(n_store * 4) + {10'b0, off};
		emit(enc_s(imm, rs, 5'd1, f3));
		exp_addr[n_store] = data_base + 32'(n_store * 4);
		case (f3)
			3'd0: exp_strb[n_store] = 4'b0001 << off;
			3'd1: exp_strb[n_store] = 4'b0011 << off;
			default: exp_strb[n_store] = 4'b1111;
		endcase
		case (f3)
			3'd0: exp_data[n_store] = {4{m_reg[rs][7:0]}};
			3'd1: exp_data[n_store] = {2{m_reg[rs][15:0]}};
			default: exp_data[n_store] = m_reg[rs];
		endcase
		n_store++;
	endtask

	task automatic arith_reg(input logic [2:0] f3, input logic alt);
		emit({1'b0, alt, 5'b0, 5'd5, 5'd4, f3, 5'd3, opc_arith_reg});
		m_reg[3] = alu_ref(f3, alt, m_reg[4], m_reg[5]);
		store_sized(5'd3, 3'd2, 2'd0);
	endtask

	task automatic arith_imm(input logic [2:0] f3, input logic alt);
		logic [11:0] imm;
		rng = xorshift(rng);
		imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, rng[4:0]} : rng[11:0];
		emit(enc_i(imm, 5'd4, f3, 5'd3, opc_arith_imm));
		m_reg[3] = alu_ref(f3, alt && f3 == 3'd5, m_reg[4], {{20{imm[11]}}, imm});
		store_sized(5'd3, 3'd2, 2'd0);
	endtask

	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		emit(enc_b(13'd8, rs2, rs1, f3));
		if (taken_ref(f3, m_reg[rs1], m_reg[rs2])) begin
			emit_skipped(enc_i(12'd1, 5'd0, 3'd0, 5'd6, opc_arith_imm));
		end else begin
			emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, opc_arith_imm));
		end
	endtask

	task automatic build_program();
		logic [31:0] pc_j;
		logic [2:0] conds [0:5];
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int r = 0; r < 32; r++) m_reg[r] = '0;
		for (int i = 0; i < 256; i++) imem[i] = '0;
		pc_gen = reset_vector;
		n_trace = 0;
		n_store = 0;
		load_imm(5'd1, data_base);
		rng = xorshift(rng);
		load_imm(5'd4, rng);
		rng = xorshift(rng);
		load_imm(5'd5, rng);
		for (int f = 0; f < 8; f++) begin
			arith_reg(3'(f), 1'b0);
			if (f == 0 || f == 5) arith_reg(3'(f), 1'b1);  // SUB and SRA
			arith_imm(3'(f), 1'b0);
		end
		arith_imm(3'd5, 1'b1);
		for (int c = 0; c < 6; c++) begin
			branch(conds[c], 5'd4, 5'd5);
			branch(conds[c], 5'd5, 5'd4);
			branch(conds[c], 5'd4, 5'd4);
		end
		pc_j = pc_gen;
		emit(enc_j(21'd8, 5'd7));
		emit_skipped('0);
		m_reg[7] = pc_j + 32'd4;
		store_sized(5'd7, 3'd2, 2'd0);
		m_reg[8] = pc_gen;  // AUIPC with zero offset
		emit({20'h0, 5'd8, opc_auipc});
		m_reg[9] = pc_gen + 32'd4;
		emit(enc_i(12'd12, 5'd8, 3'd0, 5'd9, opc_jalr));
		emit_skipped('0);
		store_sized(5'd9, 3'd2, 2'd0);
		store_sized(5'd8, 3'd2, 2'd0);
		for (int o = 0; o < 4; o++) store_sized(5'd5, 3'd0, 2'(o));
		store_sized(5'd5, 3'd1, 2'd0);
		store_sized(5'd5, 3'd1, 2'd2);
		for (int o = 0; o < 4; o++) begin
			for (int k = 0; k < 4; k++) begin
				if (k < 2 || o[0] == 1'b0) begin
					emit(enc_i(12'd224 + 12'(o), 5'd1, (k[0] ? 3'd4 : 3'd0) | 3'(k & 2) >> 1,
						5'd10, opc_load));
					m_reg[10] = load_ref((k[0] ? 3'd4 : 3'd0) | 3'(k & 2) >> 1,
						fill_word(data_base + 32'd224), 2'(o));
					store_sized(5'd10, 3'd2, 2'd0);
				end
			end
		end
		emit(enc_j(21'd0, 5'd0));  // Park in a self loop
	endtask

	// Memory models with random ready stalls
	always @(posedge clock) begin
		rng = xorshift(rng);
		if (reset) begin
			iready <= 1'b0;
			dready <= 1'b0;
		end else begin
			iready <= ivalid && !iready && rng[1:0] != 2'b00;
			idata <= imem[iaddr[9:2]];
			dready <= dvalid && !dready && rng[3:2] != 2'b00;
			drdata <= dmem[daddr[7:2]];
			if (dvalid && dready && dwrite) begin
				dmem[daddr[7:2]] <= apply_strobes(dmem[daddr[7:2]], dwdata, dstrb);
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			fetch_idx <= 0;
			st_idx <= 0;
		end else begin
			if (ivalid && iready) begin
				fetch_idx <= fetch_idx + 1;
				cur_op <= idata[6:0];
			end
			if (dvalid && dready && dwrite) st_idx <= st_idx + 1;
		end
	end

	a_reset_vector: assert property (@(posedge clock) disable iff (reset)
		(fetch_idx == 0 && ivalid && iready) |-> iaddr == reset_vector)
		else begin
			check_errors++;
			$display("FAIL %0t: first fetch at %h", $time, $sampled(iaddr));
		end

	a_fetch_order: assert property (@(posedge clock) disable iff (reset)
		(ivalid && iready && fetch_idx < n_trace) |-> iaddr == exp_pc[fetch_idx])
		else begin
			check_errors++;
			$display("FAIL %0t: fetch address %h off the model path", $time, $sampled(iaddr));
		end

	a_fetch_stable: assert property (@(posedge clock) disable iff (reset)
		($past(ivalid && !iready) && ivalid) |-> iaddr == $past(iaddr))
		else begin
			check_errors++;
			$display("FAIL %0t: iaddr changed during a fetch stall", $time);
		end

	a_data_stable: assert property (@(posedge clock) disable iff (reset)
		($past(dvalid && !dready) && dvalid) |-> (daddr == $past(daddr)
			&& dwdata == $past(dwdata) && dstrb == $past(dstrb)))
		else begin
			check_errors++;
			$display("FAIL %0t: data port changed during a stall", $time);
		end

	a_mem_only: assert property (@(posedge clock) disable iff (reset)
		dvalid |-> (cur_op == opc_load || cur_op == opc_store)
			&& (dwrite == (cur_op == opc_store)))
		else begin
			check_errors++;
			$display("FAIL %0t: data access outside a load or store", $time);
		end

	a_store: assert property (@(posedge clock) disable iff (reset)
		(dvalid && dready && dwrite) |-> (st_idx < n_store && daddr == exp_addr[st_idx]
			&& dstrb == exp_strb[st_idx] && dwdata == exp_data[st_idx]))
		else begin
			check_errors++;
			$display("FAIL %0t: store %0d addr %h strb %b data %h", $time, $sampled(st_idx),
				$sampled(daddr), $sampled(dstrb), $sampled(dwdata));
		end

	initial begin
		reset = 1'b1;
		idata = '0;
		iready = 1'b0;
		drdata = '0;
		dready = 1'b0;
		cur_op = '0;
		check_errors = 0;
		other_errors = 0;
		cycles = 0;
		rng = 32'h9884;
		for (int i = 0; i < 64; i++) dmem[i] = fill_word(data_base + 32'(i * 4));
		build_program();
		limit = n_trace * 40 * 2;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		while (fetch_idx < n_trace && cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		repeat (2) @(posedge clock);
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles with %0d of %0d fetches done",
				cycles, fetch_idx, n_trace);
			other_errors++;
		end
		if (st_idx != n_store) begin
			$display("Only %0d of %0d expected stores were seen", st_idx, n_store);
			other_errors++;
		end
		$display("Errors: %0d failed checks, %0d other", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_control.sv
design/rv_core.sv
test/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
	-f filelist.f -o tb_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "No pass line found in sim.log"
	exit 1
fi
exit 0
